// ==== compile.f ====
src/pool_pkg.sv
src/pool_arbiter.sv
src/neighbor_sel.sv
src/max_reduce.sv
src/pool_core.sv
src/pool_unit.sv
tests/glb_mem_model.sv
tests/tb_pool_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the pool_unit testbench with Verilator, run it and scan its output
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_pool_unit -Mdir obj_dir -f compile.f \
    && ./obj_dir/Vtb_pool_unit | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== src/max_reduce.sv ====
`timescale 1ns/10ps

module max_reduce
    import pool_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic [k_w-1:0]   k,
    input  logic [idx_w-1:0] nip,
    input  logic [idx_w-1:0] ofm_wr_base,
    input  logic             ofm_rd_dat_vld,
    input  logic [ofm_w-1:0] ofm_rd_dat,
    output logic             ofm_rd_dat_rdy,
    output logic             wr_vld,
    output logic [idx_w-1:0] wr_addr,
    output logic [ofm_w-1:0] wr_dat,
    input  logic             wr_rdy,
    output logic             done
);

    logic [lanes-1:0][act_w-1:0] din;
    logic [lanes-1:0][act_w-1:0] acc;
    logic [lanes-1:0][act_w-1:0] new_max;
    logic [k_w-1:0]              dat_cnt;
    logic [idx_w-1:0]            pt_cnt;
    logic [idx_w-1:0]            wr_cnt;
    logic                        last_dat;
    logic                        rd_hs;
    logic                        wr_hs;

    assign din      = ofm_rd_dat;
    assign last_dat = (dat_cnt == k - 1'b1);

    // Final datum of a point waits for a free result register
    assign ofm_rd_dat_rdy = !last_dat || !wr_vld || wr_rdy;
    assign rd_hs          = ofm_rd_dat_vld && ofm_rd_dat_rdy;
    assign wr_hs          = wr_vld && wr_rdy;
    assign done           = wr_hs && (wr_cnt == nip - 1'b1);

    // Unsigned lane max, datum 0 just loads
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            if (dat_cnt == '0 || din[i] > acc[i]) begin
                new_max[i] = din[i];
            end else begin
                new_max[i] = acc[i];
            end
        end
    end

    // ==========================================================
    // Counters and result valid
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dat_cnt <= '0;
            pt_cnt  <= '0;
            wr_cnt  <= '0;
            wr_vld  <= 1'b0;
        end else if (start) begin
            dat_cnt <= '0;
            pt_cnt  <= '0;
            wr_cnt  <= '0;
        end else begin
            if (wr_hs) begin
                wr_vld <= 1'b0;
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (rd_hs) begin
                if (last_dat) begin
                    dat_cnt <= '0;
                    pt_cnt  <= pt_cnt + 1'b1;
                    wr_vld  <= 1'b1;
                end else begin
                    dat_cnt <= dat_cnt + 1'b1;
                end
            end
        end
    end

    // Accumulator and result payload
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            acc <= new_max;
            if (last_dat) begin
                wr_dat  <= new_max;
                wr_addr <= ofm_wr_base + pt_cnt;
            end
        end
    end

    a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wr_vld && !wr_rdy |=> wr_vld && $stable(wr_addr) && $stable(wr_dat));

endmodule

// ==== src/neighbor_sel.sv ====
`timescale 1ns/10ps

module neighbor_sel
    import pool_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic [k_w-1:0]   k,
    input  logic [idx_w-1:0] ofm_rd_base,
    input  logic             map_vld,
    input  logic [map_w-1:0] map_dat,
    output logic             map_rdy,
    output logic             empty,
    output logic             ofm_rd_addr_vld,
    output logic [idx_w-1:0] ofm_rd_addr,
    input  logic             ofm_rd_addr_rdy
);

    logic [max_k-1:0][idx_w-1:0] map_word;
    logic                        full;
    logic [k_w-1:0]              nb_cnt;
    logic                        last_nb;
    logic                        addr_hs;

    // Buffer takes a word only when all k addresses are out
    assign map_rdy = !full;
    assign empty   = !full;

    assign ofm_rd_addr_vld = full;
    assign ofm_rd_addr     = ofm_rd_base + map_word[nb_cnt[$clog2(max_k)-1:0]];

    assign addr_hs = ofm_rd_addr_vld && ofm_rd_addr_rdy;
    assign last_nb = (nb_cnt == k - 1'b1);

    // ==========================================================
    // Buffer state and neighbor counter
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full   <= 1'b0;
            nb_cnt <= '0;
        end else if (map_vld && map_rdy) begin
            full   <= 1'b1;
            nb_cnt <= '0;
        end else if (addr_hs) begin
            if (last_nb) begin
                full   <= 1'b0;
                nb_cnt <= '0;
            end else begin
                nb_cnt <= nb_cnt + 1'b1;
            end
        end
    end

    // Index payload
    always_ff @(posedge clk) begin
        if (map_vld && map_rdy) begin
            map_word <= map_dat;
        end
    end

endmodule

// ==== src/pool_arbiter.sv ====
`timescale 1ns/10ps

module pool_arbiter
    import pool_pkg::*;
#(
    parameter bit track_rsp = 1'b1
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [num_cores-1:0]            req_vld,
    input  logic [num_cores-1:0][idx_w-1:0] req_addr,
    input  logic [num_cores-1:0][ofm_w-1:0] req_dat,
    output logic [num_cores-1:0]            req_rdy,
    output logic                            out_vld,
    output logic [idx_w-1:0]                out_addr,
    output logic [ofm_w-1:0]                out_dat,
    input  logic                            out_rdy,
    input  logic                            rsp_vld,
    output logic                            rsp_rdy,
    output logic [num_cores-1:0]            rsp_core_vld,
    input  logic [num_cores-1:0]            rsp_core_rdy
);

    logic [core_idx_w-1:0] last_idx;
    logic [core_idx_w-1:0] grant_idx;
    logic                  grant_vld;
    logic                  locked;
    logic [core_idx_w-1:0] lock_idx;
    logic [core_idx_w-1:0] sel_idx;
    logic                  pending;
    logic [core_idx_w-1:0] pend_idx;
    logic                  out_hs;
    logic                  rsp_hs;

    // Round-robin search, starting one past the last winner
    always_comb begin
        int cand;
        cand      = 0;
        grant_vld = 1'b0;
        grant_idx = last_idx;
        for (int i = 1; i <= num_cores; i++) begin
            cand = (int'(last_idx) + i) % num_cores;
            if (!grant_vld && req_vld[cand]) begin
                grant_vld = 1'b1;
                grant_idx = core_idx_w'(cand);
            end
        end
    end

    // A stalled grant stays with its requester
    assign sel_idx  = locked ? lock_idx : grant_idx;
    assign out_vld  = (locked || grant_vld) && !pending;
    assign out_addr = req_addr[sel_idx];
    assign out_dat  = req_dat[sel_idx];
    assign out_hs   = out_vld && out_rdy;

    always_comb begin
        for (int i = 0; i < num_cores; i++) begin
            req_rdy[i]      = out_hs && (sel_idx == core_idx_w'(i));
            rsp_core_vld[i] = pending && rsp_vld && (pend_idx == core_idx_w'(i));
        end
    end

    // Response goes back to the core that issued the address
    assign rsp_rdy = pending && rsp_core_rdy[pend_idx];
    assign rsp_hs  = rsp_vld && rsp_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_idx <= '0;
            locked   <= 1'b0;
            lock_idx <= '0;
            pending  <= 1'b0;
            pend_idx <= '0;
        end else begin
            if (out_hs) begin
                last_idx <= sel_idx;
                locked   <= 1'b0;
                pending  <= track_rsp;
                pend_idx <= sel_idx;
            end else if (out_vld) begin
                locked   <= 1'b1;
                lock_idx <= sel_idx;
            end
            if (rsp_hs) begin
                pending <= 1'b0;
            end
        end
    end

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_vld && !out_rdy |=> out_vld && $stable(out_addr));

endmodule

// ==== src/pool_core.sv ====
`timescale 1ns/10ps

module pool_core
    import pool_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cfg_vld,
    input  logic [k_w-1:0]   cfg_k,
    input  logic [idx_w-1:0] cfg_nip,
    input  logic [idx_w-1:0] cfg_map_base,
    input  logic [idx_w-1:0] cfg_ofm_rd_base,
    input  logic [idx_w-1:0] cfg_ofm_wr_base,
    output logic             cfg_rdy,
    output logic             map_req_vld,
    output logic [idx_w-1:0] map_req_addr,
    input  logic             map_req_rdy,
    input  logic             map_rsp_vld,
    input  logic [map_w-1:0] map_rsp_dat,
    output logic             map_rsp_rdy,
    output logic             ofm_rd_addr_vld,
    output logic [idx_w-1:0] ofm_rd_addr,
    input  logic             ofm_rd_addr_rdy,
    input  logic             ofm_rd_dat_vld,
    input  logic [ofm_w-1:0] ofm_rd_dat,
    output logic             ofm_rd_dat_rdy,
    output logic             wr_vld,
    output logic [idx_w-1:0] wr_addr,
    output logic [ofm_w-1:0] wr_dat,
    input  logic             wr_rdy
);

    core_state_t      state;
    logic [k_w-1:0]   k_r;
    logic [idx_w-1:0] nip_r;
    logic [idx_w-1:0] map_base_r;
    logic [idx_w-1:0] rd_base_r;
    logic [idx_w-1:0] wr_base_r;
    logic [idx_w-1:0] map_cnt;
    logic             map_pend;
    logic             sel_empty;
    logic             cfg_hs;
    logic             job_done;

    assign cfg_rdy = (state == st_idle);
    assign cfg_hs  = cfg_vld && cfg_rdy;

    // One map word in flight at a time
    assign map_req_vld  = (state == st_fetch) && sel_empty && !map_pend;
    assign map_req_addr = map_base_r + map_cnt;

    // ==========================================================
    // Job FSM and map fetch
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            k_r        <= '0;
            nip_r      <= '0;
            map_base_r <= '0;
            rd_base_r  <= '0;
            wr_base_r  <= '0;
            map_cnt    <= '0;
            map_pend   <= 1'b0;
        end else begin
            if (map_rsp_vld && map_rsp_rdy) begin
                map_pend <= 1'b0;
            end
            case (state)
                st_idle: begin
                    if (cfg_hs) begin
                        k_r        <= cfg_k;
                        nip_r      <= cfg_nip;
                        map_base_r <= cfg_map_base;
                        rd_base_r  <= cfg_ofm_rd_base;
                        wr_base_r  <= cfg_ofm_wr_base;
                        map_cnt    <= '0;
                        state      <= st_fetch;
                    end
                end
                st_fetch: begin
                    if (map_req_vld && map_req_rdy) begin
                        map_pend <= 1'b1;
                        map_cnt  <= map_cnt + 1'b1;
                        if (map_cnt == nip_r - 1'b1) begin
                            state <= st_drain;
                        end
                    end
                end
                st_drain: begin
                    if (job_done) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    neighbor_sel u_neighbor_sel (
        .clk             (clk),
        .rst_n           (rst_n),
        .k               (k_r),
        .ofm_rd_base     (rd_base_r),
        .map_vld         (map_rsp_vld),
        .map_dat         (map_rsp_dat),
        .map_rdy         (map_rsp_rdy),
        .empty           (sel_empty),
        .ofm_rd_addr_vld (ofm_rd_addr_vld),
        .ofm_rd_addr     (ofm_rd_addr),
        .ofm_rd_addr_rdy (ofm_rd_addr_rdy)
    );

    max_reduce u_max_reduce (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (cfg_hs),
        .k              (k_r),
        .nip            (nip_r),
        .ofm_wr_base    (wr_base_r),
        .ofm_rd_dat_vld (ofm_rd_dat_vld),
        .ofm_rd_dat     (ofm_rd_dat),
        .ofm_rd_dat_rdy (ofm_rd_dat_rdy),
        .wr_vld         (wr_vld),
        .wr_addr        (wr_addr),
        .wr_dat         (wr_dat),
        .wr_rdy         (wr_rdy),
        .done           (job_done)
    );

    a_cfg_legal: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_hs |-> (cfg_k >= 1) && (cfg_k <= max_k) && (cfg_nip != '0));

endmodule

// ==== src/pool_pkg.sv ====
package pool_pkg;

    // ==========================================================
    // Core and bus dimensions
    // ==========================================================
    localparam int num_cores  = 2;
    localparam int core_idx_w = 1;

    // Addresses, point counts and neighbor indices
    localparam int idx_w = 8;

    // Neighbor count range
    localparam int max_k = 4;
    localparam int k_w   = 3;

    // Activation word with four 8-bit lanes
    localparam int lanes = 4;
    localparam int act_w = 8;
    localparam int ofm_w = lanes * act_w;

    // Map word, index 0 in the low byte
    localparam int map_w = max_k * idx_w;

    // ==========================================================
    // Pool core job states
    // ==========================================================
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_fetch = 2'd1,
        st_drain = 2'd2
    } core_state_t;

endpackage

// ==== src/pool_unit.sv ====
`timescale 1ns/10ps

module pool_unit
    import pool_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [num_cores-1:0]            cfg_vld,
    input  logic [num_cores-1:0][k_w-1:0]   cfg_k,
    input  logic [num_cores-1:0][idx_w-1:0] cfg_nip,
    input  logic [num_cores-1:0][idx_w-1:0] cfg_map_base,
    input  logic [num_cores-1:0][idx_w-1:0] cfg_ofm_rd_base,
    input  logic [num_cores-1:0][idx_w-1:0] cfg_ofm_wr_base,
    output logic [num_cores-1:0]            cfg_rdy,
    output logic                            map_rd_addr_vld,
    output logic [idx_w-1:0]                map_rd_addr,
    input  logic                            map_rd_addr_rdy,
    input  logic                            map_rd_dat_vld,
    input  logic [map_w-1:0]                map_rd_dat,
    output logic                            map_rd_dat_rdy,
    output logic [num_cores-1:0]            ofm_rd_addr_vld,
    output logic [num_cores-1:0][idx_w-1:0] ofm_rd_addr,
    input  logic [num_cores-1:0]            ofm_rd_addr_rdy,
    input  logic [num_cores-1:0]            ofm_rd_dat_vld,
    input  logic [num_cores-1:0][ofm_w-1:0] ofm_rd_dat,
    output logic [num_cores-1:0]            ofm_rd_dat_rdy,
    output logic                            ofm_wr_vld,
    output logic [idx_w-1:0]                ofm_wr_addr,
    output logic [ofm_w-1:0]                ofm_wr_dat,
    input  logic                            ofm_wr_rdy
);

    logic [num_cores-1:0]            core_map_req_vld;
    logic [num_cores-1:0][idx_w-1:0] core_map_req_addr;
    logic [num_cores-1:0]            core_map_req_rdy;
    logic [num_cores-1:0]            core_map_rsp_vld;
    logic [num_cores-1:0]            core_map_rsp_rdy;
    logic [num_cores-1:0]            core_wr_vld;
    logic [num_cores-1:0][idx_w-1:0] core_wr_addr;
    logic [num_cores-1:0][ofm_w-1:0] core_wr_dat;
    logic [num_cores-1:0]            core_wr_rdy;

    // ==========================================================
    // Pool cores
    // ==========================================================
    for (genvar c = 0; c < num_cores; c++) begin : g_core
        pool_core u_pool_core (
            .clk             (clk),
            .rst_n           (rst_n),
            .cfg_vld         (cfg_vld[c]),
            .cfg_k           (cfg_k[c]),
            .cfg_nip         (cfg_nip[c]),
            .cfg_map_base    (cfg_map_base[c]),
            .cfg_ofm_rd_base (cfg_ofm_rd_base[c]),
            .cfg_ofm_wr_base (cfg_ofm_wr_base[c]),
            .cfg_rdy         (cfg_rdy[c]),
            .map_req_vld     (core_map_req_vld[c]),
            .map_req_addr    (core_map_req_addr[c]),
            .map_req_rdy     (core_map_req_rdy[c]),
            .map_rsp_vld     (core_map_rsp_vld[c]),
            .map_rsp_dat     (map_rd_dat),
            .map_rsp_rdy     (core_map_rsp_rdy[c]),
            .ofm_rd_addr_vld (ofm_rd_addr_vld[c]),
            .ofm_rd_addr     (ofm_rd_addr[c]),
            .ofm_rd_addr_rdy (ofm_rd_addr_rdy[c]),
            .ofm_rd_dat_vld  (ofm_rd_dat_vld[c]),
            .ofm_rd_dat      (ofm_rd_dat[c]),
            .ofm_rd_dat_rdy  (ofm_rd_dat_rdy[c]),
            .wr_vld          (core_wr_vld[c]),
            .wr_addr         (core_wr_addr[c]),
            .wr_dat          (core_wr_dat[c]),
            .wr_rdy          (core_wr_rdy[c])
        );
    end

    // Shared map-read port, responses routed back per core
    pool_arbiter #(
        .track_rsp (1'b1)
    ) u_map_arb (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_vld      (core_map_req_vld),
        .req_addr     (core_map_req_addr),
        .req_dat      ('0),
        .req_rdy      (core_map_req_rdy),
        .out_vld      (map_rd_addr_vld),
        .out_addr     (map_rd_addr),
        .out_dat      (),
        .out_rdy      (map_rd_addr_rdy),
        .rsp_vld      (map_rd_dat_vld),
        .rsp_rdy      (map_rd_dat_rdy),
        .rsp_core_vld (core_map_rsp_vld),
        .rsp_core_rdy (core_map_rsp_rdy)
    );

    // Shared result-write port
    pool_arbiter #(
        .track_rsp (1'b0)
    ) u_wr_arb (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_vld      (core_wr_vld),
        .req_addr     (core_wr_addr),
        .req_dat      (core_wr_dat),
        .req_rdy      (core_wr_rdy),
        .out_vld      (ofm_wr_vld),
        .out_addr     (ofm_wr_addr),
        .out_dat      (ofm_wr_dat),
        .out_rdy      (ofm_wr_rdy),
        .rsp_vld      (1'b0),
        .rsp_rdy      (),
        .rsp_core_vld (),
        .rsp_core_rdy ('0)
    );

endmodule

// ==== tests/glb_mem_model.sv ====
`timescale 1ns/10ps

module glb_mem_model
    import pool_pkg::*;
(
    input  logic                            clk,
    input  logic                            bp_en,
    input  logic                            map_rd_addr_vld,
    input  logic [idx_w-1:0]                map_rd_addr,
    output logic                            map_rd_addr_rdy,
    output logic                            map_rd_dat_vld,
    output logic [map_w-1:0]                map_rd_dat,
    input  logic                            map_rd_dat_rdy,
    input  logic [num_cores-1:0]            ofm_rd_addr_vld,
    input  logic [num_cores-1:0][idx_w-1:0] ofm_rd_addr,
    output logic [num_cores-1:0]            ofm_rd_addr_rdy,
    output logic [num_cores-1:0]            ofm_rd_dat_vld,
    output logic [num_cores-1:0][ofm_w-1:0] ofm_rd_dat,
    input  logic [num_cores-1:0]            ofm_rd_dat_rdy,
    output logic                            ofm_wr_rdy
);

    logic [map_w-1:0] map_mem [256];
    logic [ofm_w-1:0] act_mem [256];

    // Pending responses, due cycle in the upper half
    logic [63:0] map_q [$];
    logic [63:0] act_q [num_cores][$];

    logic [31:0] lfsr;
    int          cycle;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One pseudo-random bit per call
    function logic rand_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    function logic ready_bit();
        if (!bp_en) begin
            return 1'b1;
        end
        return rand_bit();
    endfunction

    // ==========================================================
    // Sample handshakes at the falling edge, answer after the rising one
    // ==========================================================
    initial begin
        logic                            map_addr_hs;
        logic                            map_dat_hs;
        logic [idx_w-1:0]                map_a;
        logic [num_cores-1:0]            addr_hs;
        logic [num_cores-1:0]            dat_hs;
        logic [num_cores-1:0][idx_w-1:0] act_a;
        logic [31:0]                     due;
        logic [63:0]                     head;
        logic [7:0]                      b;
        lfsr  = 32'd73724;
        cycle = 0;
        for (int a = 0; a < 256; a++) begin
            b = a[7:0];
            map_mem[a] = {b ^ 8'h3c, b, ~b, b + 8'd1};
            act_mem[a] = {~b, b ^ 8'ha5, b, b + 8'd7};
        end
        map_rd_addr_rdy = 1'b0;
        map_rd_dat_vld  = 1'b0;
        map_rd_dat      = '0;
        ofm_rd_addr_rdy = '0;
        ofm_rd_dat_vld  = '0;
        ofm_rd_dat      = '0;
        ofm_wr_rdy      = 1'b0;
        forever begin
            @(negedge clk);
            map_addr_hs = map_rd_addr_vld && map_rd_addr_rdy;
            map_a       = map_rd_addr;
            map_dat_hs  = map_rd_dat_vld && map_rd_dat_rdy;
            addr_hs     = ofm_rd_addr_vld & ofm_rd_addr_rdy;
            act_a       = ofm_rd_addr;
            dat_hs      = ofm_rd_dat_vld & ofm_rd_dat_rdy;
            @(posedge clk);
            #1;
            cycle++;
            if (map_dat_hs) begin
                map_rd_dat_vld = 1'b0;
            end
            if (map_addr_hs) begin
                due = cycle + rand_bit();
                map_q.push_back({due, map_mem[map_a]});
            end
            if (!map_rd_dat_vld && map_q.size() > 0) begin
                head = map_q[0];
                if (head[63:32] <= cycle) begin
                    map_rd_dat     = head[31:0];
                    map_rd_dat_vld = 1'b1;
                    void'(map_q.pop_front());
                end
            end
            // Per-core queues keep activation responses in order
            for (int c = 0; c < num_cores; c++) begin
                if (dat_hs[c]) begin
                    ofm_rd_dat_vld[c] = 1'b0;
                end
                if (addr_hs[c]) begin
                    due = cycle + rand_bit();
                    act_q[c].push_back({due, act_mem[act_a[c]]});
                end
                if (!ofm_rd_dat_vld[c] && act_q[c].size() > 0) begin
                    head = act_q[c][0];
                    if (head[63:32] <= cycle) begin
                        ofm_rd_dat[c]     = head[31:0];
                        ofm_rd_dat_vld[c] = 1'b1;
                        void'(act_q[c].pop_front());
                    end
                end
            end
            map_rd_addr_rdy = ready_bit();
            for (int c = 0; c < num_cores; c++) begin
                ofm_rd_addr_rdy[c] = ready_bit();
            end
            ofm_wr_rdy = ready_bit();
        end
    end

endmodule

// ==== tests/pool_stim.txt ====
# m addr map_word | a addr act_word | e wr_addr wr_data (all hex, lane 0 in the low byte)
# j core k nip map_base rd_base wr_base together bp (together: start without waiting for idle)
m 00 03020100
m 01 07060504
m 02 07050301
m 03 05030206
m 04 00040703
a 10 11223344
a 11 8005ff01
a 12 7f901020
a 13 00aa55c3
a 14 fe01807f
a 15 33cc0ff0
a 16 01020304
a 17 c03ca55a
# Jobs in issue order
j 0 4 3 00 10 80 0 0
j 1 1 2 03 10 90 0 0
j 0 2 2 01 10 a0 0 0
j 1 3 2 00 10 b0 1 0
j 1 4 3 00 10 c0 0 1
j 0 2 2 01 10 d0 1 1
# Expected result writes
e 80 80aaffc3
e 81 fecca5f0
e 82 c0ccfff0
e 90 01020304
e 91 00aa55c3
e a0 fecc80f0
e a1 80aaffc3
e b0 8090ff44
e b1 fecc80f0
e c0 80aaffc3
e c1 fecca5f0
e c2 c0ccfff0
e d0 fecc80f0
e d1 80aaffc3

// ==== tests/tb_pool_unit.sv ====
`timescale 1ns/10ps

module tb_pool_unit
    import pool_pkg::*;
();

    logic                            clk;
    logic                            rst_n;
    logic [num_cores-1:0]            cfg_vld;
    logic [num_cores-1:0][k_w-1:0]   cfg_k;
    logic [num_cores-1:0][idx_w-1:0] cfg_nip;
    logic [num_cores-1:0][idx_w-1:0] cfg_map_base;
    logic [num_cores-1:0][idx_w-1:0] cfg_ofm_rd_base;
    logic [num_cores-1:0][idx_w-1:0] cfg_ofm_wr_base;
    logic [num_cores-1:0]            cfg_rdy;
    logic                            map_rd_addr_vld;
    logic [idx_w-1:0]                map_rd_addr;
    logic                            map_rd_addr_rdy;
    logic                            map_rd_dat_vld;
    logic [map_w-1:0]                map_rd_dat;
    logic                            map_rd_dat_rdy;
    logic [num_cores-1:0]            ofm_rd_addr_vld;
    logic [num_cores-1:0][idx_w-1:0] ofm_rd_addr;
    logic [num_cores-1:0]            ofm_rd_addr_rdy;
    logic [num_cores-1:0]            ofm_rd_dat_vld;
    logic [num_cores-1:0][ofm_w-1:0] ofm_rd_dat;
    logic [num_cores-1:0]            ofm_rd_dat_rdy;
    logic                            ofm_wr_vld;
    logic [idx_w-1:0]                ofm_wr_addr;
    logic [ofm_w-1:0]                ofm_wr_dat;
    logic                            ofm_wr_rdy;
    logic                            bp_en;

    // Expected result table indexed by write address
    logic [ofm_w-1:0] exp_dat [256];
    bit               exp_vld [256];
    int               wr_seen [256];

    // One row per job with core k nip map_base rd_base wr_base together bp
    logic [7:0] job [16][8];

    int n_jobs;
    int n_exp;
    int n_wr;
    int errors;
    bit stim_ok;

    pool_unit dut (.*);

    glb_mem_model mem (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    // ==========================================================
    // Stimulus file
    // ==========================================================
    task automatic load_stim();
        int               fd;
        int               rc;
        int               want;
        logic [7:0]       tag;
        logic [31:0]      a;
        logic [31:0]      d;
        logic [8*128-1:0] rest;
        fd = $fopen("tests/pool_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open the stimulus file tests/pool_stim.txt");
            return;
        end
        while ($fscanf(fd, " %c", tag) == 1) begin
            want = 0;
            case (tag)
                "#": rc = $fgets(rest, fd);
                "m": begin
                    want = 2;
                    rc   = $fscanf(fd, "%h %h", a, d);
                    mem.map_mem[a[7:0]] = d;
                end
                "a": begin
                    want = 2;
                    rc   = $fscanf(fd, "%h %h", a, d);
                    mem.act_mem[a[7:0]] = d;
                end
                "j": begin
                    want = 8;
                    rc   = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                                   job[n_jobs][0], job[n_jobs][1], job[n_jobs][2],
                                   job[n_jobs][3], job[n_jobs][4], job[n_jobs][5],
                                   job[n_jobs][6], job[n_jobs][7]);
                    n_jobs++;
                end
                "e": begin
                    want = 2;
                    rc   = $fscanf(fd, "%h %h", a, d);
                    exp_vld[a[7:0]] = 1'b1;
                    exp_dat[a[7:0]] = d;
                    n_exp++;
                end
                default: begin
                    errors++;
                    $display("Unknown record type in the stimulus file");
                    rc = $fgets(rest, fd);
                end
            endcase
            if (rc < want) begin
                errors++;
                $display("Record of type %c in the stimulus file has missing fields", tag);
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_idle();
        while (cfg_rdy != {num_cores{1'b1}}) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Together jobs skip the wait for all cores idle
    task automatic start_job(input int j);
        int c;
        c = job[j][0];
        if (job[j][6] == 8'h0) begin
            wait_idle();
        end
        while (!cfg_rdy[c]) begin
            @(posedge clk);
            #1;
        end
        bp_en              = job[j][7][0];
        cfg_k[c]           = job[j][1][k_w-1:0];
        cfg_nip[c]         = job[j][2];
        cfg_map_base[c]    = job[j][3];
        cfg_ofm_rd_base[c] = job[j][4];
        cfg_ofm_wr_base[c] = job[j][5];
        cfg_vld[c]         = 1'b1;
        @(posedge clk);
        #1;
        cfg_vld[c] = 1'b0;
    endtask

    // ==========================================================
    // Write monitor
    // ==========================================================
    always @(negedge clk) begin
        if (rst_n && ofm_wr_vld && ofm_wr_rdy) begin
            n_wr++;
            if (!exp_vld[ofm_wr_addr]) begin
                errors++;
                $display("Write to address 0x%02h is not in the expected table", ofm_wr_addr);
            end else begin
                if (wr_seen[ofm_wr_addr] > 0) begin
                    errors++;
                    $display("Address 0x%02h was written more than once", ofm_wr_addr);
                end
                check_val("ofm_wr_dat", ofm_wr_dat, exp_dat[ofm_wr_addr]);
            end
            wr_seen[ofm_wr_addr]++;
        end
    end

    initial begin
        int limit;
        wait (stim_ok);
        limit = 200 * n_exp + 500;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, jobs unfinished, %0d errors", limit, errors);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial begin
        rst_n           = 1'b0;
        cfg_vld         = '0;
        cfg_k           = '0;
        cfg_nip         = '0;
        cfg_map_base    = '0;
        cfg_ofm_rd_base = '0;
        cfg_ofm_wr_base = '0;
        bp_en           = 1'b0;
        errors          = 0;
        n_jobs          = 0;
        n_exp           = 0;
        n_wr            = 0;
        stim_ok         = 1'b0;
        repeat (2) @(posedge clk);
        load_stim();
        stim_ok = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Idle outputs straight after reset
        @(negedge clk);
        check_val("cfg_rdy", cfg_rdy, {num_cores{1'b1}});
        check_val("map_rd_addr_vld", map_rd_addr_vld, 0);
        check_val("ofm_rd_addr_vld", ofm_rd_addr_vld, 0);
        check_val("ofm_wr_vld", ofm_wr_vld, 0);
        @(posedge clk);
        #1;

        for (int j = 0; j < n_jobs; j++) begin
            start_job(j);
        end
        wait_idle();
        repeat (4) @(posedge clk);

        for (int a = 0; a < 256; a++) begin
            if (exp_vld[a] && wr_seen[a] == 0) begin
                errors++;
                $display("No write arrived for expected address 0x%02h", a);
            end
        end
        $display("Run finished: %0d jobs, %0d writes seen, %0d expected, %0d errors",
                 n_jobs, n_wr, n_exp, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
